/* verilog/tri_mem_pkg.sv */
package tri_mem_pkg;

    // scene capacity in triangles
    localparam int num_triangle = 512;
    localparam int tri_id_w     = $clog2(num_triangle);

    // four index words per triangle: v0, v1, v2, sid
    localparam int mem_addr_w   = tri_id_w + 2;

    // table word and host word
    localparam int word_w       = 32;

    // one vertex is z, y, x with x in the low word
    localparam int vertex_w     = 3 * word_w;

    // one load word carries four lanes
    localparam int load_w       = 4 * word_w;

    // triangle store FSM
    typedef enum logic [2:0] {
        idle,
        wr_index,
        wr_vertex,
        rd_0,
        rd_1,
        rd_2,
        rd_sid,
        rd_done
    } store_state_e;

    // scene loader FSM
    typedef enum logic [1:0] {
        collect,
        send,
        wait_rdy
    } loader_state_e;

endpackage

/* verilog/single_port_ram.sv */
`timescale 1ns/10ps

module single_port_ram (
    input  logic                               clk,
    input  logic                               we,
    input  logic [tri_mem_pkg::mem_addr_w-1:0] addr,
    input  logic [tri_mem_pkg::word_w-1:0]     data,
    output logic [tri_mem_pkg::word_w-1:0]     q
);

    import tri_mem_pkg::*;

    logic [word_w-1:0] mem [2**mem_addr_w];

    // q returns the old word when written in the same cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

/* verilog/mem_triangle.sv */
`timescale 1ns/10ps

module mem_triangle (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               rd_req,
    input  logic [tri_mem_pkg::tri_id_w-1:0]   triangle_id,
    input  logic [tri_mem_pkg::load_w-1:0]     load_data,
    input  logic                               load_we,
    output logic                               load_rdy,
    output logic                               rd_rdy,
    output logic                               rd_not_valid,
    output logic [tri_mem_pkg::vertex_w-1:0]   vertex0,
    output logic [tri_mem_pkg::vertex_w-1:0]   vertex1,
    output logic [tri_mem_pkg::vertex_w-1:0]   vertex2,
    output logic [tri_mem_pkg::word_w-1:0]     sid
);

    import tri_mem_pkg::*;

    store_state_e state, state_d;

    // load side
    logic [load_w-1:0]     load_buf;
    logic [1:0]            lane_cnt, lane_cnt_d;
    logic [mem_addr_w-1:0] wr_addr, wr_addr_d;
    logic                  load_rdy_d;
    logic                  top_zero;
    logic                  loading;
    logic                  load_start;

    // read side
    logic                  req_q;
    logic [tri_id_w-1:0]   req_id_q;
    logic                  bad_req;
    logic                  in_read;
    logic                  rd_rdy_d;
    logic [tri_id_w-1:0]   valid_max, valid_max_d;
    logic [tri_id_w-1:0]   cur_id, cur_id_d;

    // prefetch bookkeeping
    logic                  pf_active, pf_active_d;
    logic                  pf_want, pf_want_d;
    logic [tri_id_w-1:0]   next_id, next_id_d;
    logic                  buf_valid, buf_valid_d;
    logic [tri_id_w-1:0]   buf_id, buf_id_d;
    logic                  req_hit;

    // RAM ports
    logic                  index_we;
    logic [mem_addr_w-1:0] index_addr;
    logic [word_w-1:0]     index_q;
    logic                  vertex_we;
    logic [mem_addr_w-1:0] vertex_addr;
    logic [word_w-1:0]     coord_q [3];
    logic [vertex_w-1:0]   ram_vertex;

    // output buffers
    logic [vertex_w-1:0]   vtx_buf [3];
    logic [word_w-1:0]     sid_buf;

    assign top_zero   = ~|load_data[load_w-1:load_w-word_w];
    assign loading    = (state == wr_index) || (state == wr_vertex);
    assign in_read    = state inside {rd_0, rd_1, rd_2, rd_sid, rd_done};
    assign load_start = load_we && !loading && !top_zero;
    assign bad_req    = rd_req && (triangle_id > valid_max);
    assign req_hit    = buf_valid && (buf_id == req_id_q);

    always_comb begin
        state_d     = state;
        load_rdy_d  = load_rdy;
        lane_cnt_d  = lane_cnt;
        wr_addr_d   = wr_addr;
        valid_max_d = valid_max;
        rd_rdy_d    = 1'b0;
        cur_id_d    = cur_id;
        pf_active_d = pf_active;
        pf_want_d   = pf_want;
        next_id_d   = next_id;
        buf_valid_d = buf_valid;
        buf_id_d    = buf_id;
        case (state)
            wr_index: begin
                if (!load_rdy) begin
                    // one index lane per cycle
                    lane_cnt_d = lane_cnt + 2'd1;
                    wr_addr_d  = wr_addr + 1'b1;
                    if (lane_cnt == 2'd3) begin
                        load_rdy_d = 1'b1;
                    end
                end else if (load_we) begin
                    if (top_zero) begin
                        // record count minus one, wraps cleanly at full capacity
                        valid_max_d = wr_addr[mem_addr_w-1:2] - 1'b1;
                        wr_addr_d   = '0;
                        state_d     = wr_vertex;
                    end else begin
                        load_rdy_d = 1'b0;
                    end
                end
            end
            wr_vertex: begin
                if (load_we) begin
                    if (top_zero) begin
                        // scene complete, warm up with triangle 0
                        state_d   = idle;
                        pf_want_d = 1'b1;
                        next_id_d = '0;
                    end else begin
                        wr_addr_d = wr_addr + 1'b1;
                    end
                end
            end
            rd_0: begin
                state_d = rd_1;
            end
            rd_1: begin
                state_d = rd_2;
            end
            rd_2: begin
                state_d = rd_sid;
            end
            rd_sid: begin
                state_d  = rd_done;
                // demand read answers while in rd_done
                rd_rdy_d = !pf_active || req_q;
            end
            rd_done: begin
                state_d = idle;
                if (pf_active && !req_q) begin
                    buf_valid_d = 1'b1;
                    buf_id_d    = cur_id;
                end else begin
                    // request caught the prefetch in its last cycle
                    rd_rdy_d  = pf_active;
                    pf_want_d = 1'b1;
                    next_id_d = cur_id + 1'b1;
                end
            end
            default: begin
                if (req_q && req_hit) begin
                    rd_rdy_d    = 1'b1;
                    buf_valid_d = 1'b0;
                    pf_want_d   = 1'b1;
                    next_id_d   = req_id_q + 1'b1;
                end else if (req_q) begin
                    cur_id_d    = req_id_q;
                    pf_active_d = 1'b0;
                    pf_want_d   = 1'b0;
                    buf_valid_d = 1'b0;
                    state_d     = rd_0;
                end else if (pf_want) begin
                    pf_want_d = 1'b0;
                    if (next_id <= valid_max) begin
                        cur_id_d    = next_id;
                        pf_active_d = 1'b1;
                        buf_valid_d = 1'b0;
                        state_d     = rd_0;
                    end
                end
            end
        endcase

        // request during a walk: same id turns into a demand read, other id restarts
        if (in_read && req_q) begin
            pf_active_d = 1'b0;
            if (req_id_q != cur_id) begin
                state_d     = rd_0;
                cur_id_d    = req_id_q;
                rd_rdy_d    = 1'b0;
                pf_want_d   = 1'b0;
                buf_valid_d = 1'b0;
            end
        end

        // out of range id drops any prefetch
        if (bad_req && !loading) begin
            state_d     = idle;
            rd_rdy_d    = 1'b0;
            pf_active_d = 1'b0;
            pf_want_d   = 1'b0;
            buf_valid_d = 1'b0;
        end

        if (load_start) begin
            state_d     = wr_index;
            load_rdy_d  = 1'b0;
            lane_cnt_d  = '0;
            wr_addr_d   = '0;
            rd_rdy_d    = 1'b0;
            pf_active_d = 1'b0;
            pf_want_d   = 1'b0;
            buf_valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state        <= idle;
            load_rdy     <= 1'b1;
            lane_cnt     <= '0;
            wr_addr      <= '0;
            valid_max    <= '0;
            req_q        <= 1'b0;
            rd_rdy       <= 1'b0;
            rd_not_valid <= 1'b0;
            cur_id       <= '0;
            pf_active    <= 1'b0;
            pf_want      <= 1'b0;
            next_id      <= '0;
            buf_valid    <= 1'b0;
            buf_id       <= '0;
        end else begin
            state        <= state_d;
            load_rdy     <= load_rdy_d;
            lane_cnt     <= lane_cnt_d;
            wr_addr      <= wr_addr_d;
            valid_max    <= valid_max_d;
            req_q        <= rd_req && !bad_req;
            rd_rdy       <= rd_rdy_d;
            rd_not_valid <= bad_req;
            cur_id       <= cur_id_d;
            pf_active    <= pf_active_d;
            pf_want      <= pf_want_d;
            next_id      <= next_id_d;
            buf_valid    <= buf_valid_d;
            buf_id       <= buf_id_d;
        end
    end

    always_ff @(posedge clk) begin
        if (load_we) begin
            load_buf <= load_data;
        end
        if (rd_req) begin
            req_id_q <= triangle_id;
        end
    end

    // index table address per walk step
    always_comb begin
        case (state)
            wr_index: index_addr = wr_addr;
            rd_1:     index_addr = {cur_id, 2'd1};
            rd_2:     index_addr = {cur_id, 2'd2};
            rd_sid:   index_addr = {cur_id, 2'd3};
            default:  index_addr = {cur_id, 2'd0};
        endcase
    end

    assign index_we    = (state == wr_index) && !load_rdy;
    assign vertex_we   = (state == wr_vertex) && load_we && !top_zero;
    // index word read last cycle addresses the vertex tables
    assign vertex_addr = (state == wr_vertex) ? wr_addr : index_q[mem_addr_w-1:0];

    single_port_ram u_index_ram (
        .clk  (clk),
        .we   (index_we),
        .addr (index_addr),
        .data (load_buf[lane_cnt*word_w +: word_w]),
        .q    (index_q)
    );

    // x, y and z tables
    for (genvar i = 0; i < 3; i++) begin : g_coord
        single_port_ram u_coord_ram (
            .clk  (clk),
            .we   (vertex_we),
            .addr (vertex_addr),
            .data (load_data[i*word_w +: word_w]),
            .q    (coord_q[i])
        );
    end

    assign ram_vertex = {coord_q[2], coord_q[1], coord_q[0]};

    always_ff @(posedge clk) begin
        if (state == rd_2) begin
            vtx_buf[0] <= ram_vertex;
        end
        if (state == rd_sid) begin
            vtx_buf[1] <= ram_vertex;
        end
        if (state == rd_done) begin
            vtx_buf[2] <= ram_vertex;
            sid_buf    <= index_q;
        end
    end

    assign vertex0 = vtx_buf[0];
    assign vertex1 = vtx_buf[1];
    // a demand read hands out the last vertex and sid straight from the RAMs
    assign vertex2 = (state == rd_done) ? ram_vertex : vtx_buf[2];
    assign sid     = (state == rd_done) ? index_q : sid_buf;

    a_rdy_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(rd_rdy && rd_not_valid))
        else $error("rd_rdy and rd_not_valid high together");

    a_load_rdy: assert property (@(posedge clk) disable iff (!rst_n)
        load_we |-> load_rdy)
        else $error("load_we while load_rdy low");

endmodule

/* verilog/scene_loader.sv */
`timescale 1ns/10ps

module scene_loader (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           host_wr,
    input  logic [tri_mem_pkg::word_w-1:0] host_data,
    input  logic                           load_rdy,
    output logic                           host_busy,
    output logic                           load_we,
    output logic [tri_mem_pkg::load_w-1:0] load_data
);

    import tri_mem_pkg::*;

    loader_state_e state, state_d;

    logic [1:0]        lane_cnt;
    logic              take_word;
    logic [load_w-1:0] hold;

    // host words only count while collecting
    assign take_word = host_wr && (state == collect);

    always_comb begin
        state_d = state;
        case (state)
            collect: begin
                if (take_word && (lane_cnt == 2'd3)) begin
                    // store ready now stays ready until it sees load_we
                    state_d = load_rdy ? send : wait_rdy;
                end
            end
            wait_rdy: begin
                if (load_rdy) begin
                    state_d = send;
                end
            end
            default: begin
                // send lasts a single cycle
                state_d = collect;
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state    <= collect;
            lane_cnt <= '0;
        end else begin
            state <= state_d;
            if (take_word) begin
                lane_cnt <= lane_cnt + 2'd1;
            end
        end
    end

    // first word of a group ends up in lane 0
    always_ff @(posedge clk) begin
        if (take_word) begin
            hold <= {host_data, hold[load_w-1:word_w]};
        end
    end

    assign load_we   = (state == send);
    assign host_busy = (state != collect);
    assign load_data = hold;

    a_we_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        load_we |=> !load_we)
        else $error("load_we held longer than one cycle");

endmodule

/* verilog/triangle_store_top.sv */
`timescale 1ns/10ps

module triangle_store_top (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             host_wr,
    input  logic [tri_mem_pkg::word_w-1:0]   host_data,
    input  logic                             rd_req,
    input  logic [tri_mem_pkg::tri_id_w-1:0] triangle_id,
    output logic                             host_busy,
    output logic                             rd_rdy,
    output logic                             rd_not_valid,
    output logic [tri_mem_pkg::vertex_w-1:0] vertex0,
    output logic [tri_mem_pkg::vertex_w-1:0] vertex1,
    output logic [tri_mem_pkg::vertex_w-1:0] vertex2,
    output logic [tri_mem_pkg::word_w-1:0]   sid
);

    import tri_mem_pkg::*;

    // loader to store
    logic              load_we;
    logic              load_rdy;
    logic [load_w-1:0] load_data;

    scene_loader u_loader (
        .clk       (clk),
        .rst_n     (rst_n),
        .host_wr   (host_wr),
        .host_data (host_data),
        .load_rdy  (load_rdy),
        .host_busy (host_busy),
        .load_we   (load_we),
        .load_data (load_data)
    );

    mem_triangle u_store (
        .clk          (clk),
        .rst_n        (rst_n),
        .rd_req       (rd_req),
        .triangle_id  (triangle_id),
        .load_data    (load_data),
        .load_we      (load_we),
        .load_rdy     (load_rdy),
        .rd_rdy       (rd_rdy),
        .rd_not_valid (rd_not_valid),
        .vertex0      (vertex0),
        .vertex1      (vertex1),
        .vertex2      (vertex2),
        .sid          (sid)
    );

endmodule

/* bench/tb_triangle_store.sv */
`timescale 1ns/10ps

module tb_triangle_store;

    import tri_mem_pkg::*;

    localparam int resp_timeout = 30;

    logic                clk;
    logic                rst_n;
    logic                host_wr;
    logic [word_w-1:0]   host_data;
    logic                rd_req;
    logic [tri_id_w-1:0] triangle_id;
    logic                host_busy;
    logic                rd_rdy;
    logic                rd_not_valid;
    logic [vertex_w-1:0] vertex0;
    logic [vertex_w-1:0] vertex1;
    logic [vertex_w-1:0] vertex2;
    logic [word_w-1:0]   sid;

    // current scene with x, y and z per vertex in coord
    int                  n_tri;
    int                  n_vtx;
    logic [word_w-1:0]   tri_idx [num_triangle][3];
    logic [word_w-1:0]   tri_sid [num_triangle];
    logic [word_w-1:0]   coord [2**mem_addr_w][3];

    // open request and tallies
    int                  exp_id;
    logic                pending;
    int                  wait_cnt;
    int                  resp_cnt;
    int                  checks;
    int                  errors;
    int                  wd_cycles;

    triangle_store_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .host_wr      (host_wr),
        .host_data    (host_data),
        .rd_req       (rd_req),
        .triangle_id  (triangle_id),
        .host_busy    (host_busy),
        .rd_rdy       (rd_rdy),
        .rd_not_valid (rd_not_valid),
        .vertex0      (vertex0),
        .vertex1      (vertex1),
        .vertex2      (vertex2),
        .sid          (sid)
    );

    always #4 clk = ~clk;

    // expected triangle from the scene arrays or 0 for an id beyond the scene
    function automatic logic expected_triangle(input int id,
            output logic [2:0][vertex_w-1:0] v, output logic [word_w-1:0] s);
        logic [mem_addr_w-1:0] a;
        v = '0;
        s = '0;
        if (id >= n_tri) begin
            return 1'b0;
        end
        for (int k = 0; k < 3; k++) begin
            a = tri_idx[id][k][mem_addr_w-1:0];
            v[k] = {coord[a][2], coord[a][1], coord[a][0]};
        end
        s = tri_sid[id];
        return 1'b1;
    endfunction

    task automatic report_mismatch(input string name, input logic [vertex_w-1:0] got,
            input logic [vertex_w-1:0] exp);
        errors++;
        $display("ERR %s id %0d: got %h expected %h", name, exp_id, got, exp);
    endtask

    task automatic check_reset_low(input string name, input logic value);
        if (value !== 1'b0) begin
            errors++;
            $display("ERR %s after reset: got %h expected 0", name, value);
        end
    endtask

    task automatic check_answer();
        logic [2:0][vertex_w-1:0] v;
        logic [word_w-1:0]        s;
        logic                     valid;
        valid = expected_triangle(exp_id, v, s);
        checks++;
        if (!valid) begin
            if (!rd_not_valid)
                report_mismatch("rd_not_valid", rd_not_valid, 1'b1);
            if (rd_rdy)
                report_mismatch("rd_rdy", rd_rdy, 1'b0);
        end else if (!rd_rdy || rd_not_valid) begin
            report_mismatch("rd_not_valid", rd_not_valid, 1'b0);
        end else begin
            if (vertex0 !== v[0])
                report_mismatch("vertex0", vertex0, v[0]);
            if (vertex1 !== v[1])
                report_mismatch("vertex1", vertex1, v[1]);
            if (vertex2 !== v[2])
                report_mismatch("vertex2", vertex2, v[2]);
            if (sid !== s)
                report_mismatch("sid", sid, s);
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (rd_rdy || rd_not_valid) begin
                if (pending) begin
                    check_answer();
                    pending = 1'b0;
                    resp_cnt++;
                end else begin
                    errors++;
                    $display("response at %0t with no request open", $time);
                end
            end else if (pending) begin
                wait_cnt++;
                if (wait_cnt > resp_timeout) begin
                    errors++;
                    $display("no response to the request for id %0d", exp_id);
                    pending = 1'b0;
                    resp_cnt++;
                end
            end
        end
    end

    task automatic send_word(input logic [word_w-1:0] w);
        @(negedge clk);
        while (host_busy) begin
            host_wr = 1'b0;
            @(negedge clk);
        end
        host_wr   = 1'b1;
        host_data = w;
    endtask

    task automatic build_scene(input int n, input int v);
        n_tri = n;
        n_vtx = v;
        for (int t = 0; t < n; t++) begin
            for (int k = 0; k < 3; k++) begin
                tri_idx[t][k] = $urandom_range(v - 1, 0);
            end
            tri_sid[t] = $urandom_range(32'hffff_ffff, 1);
        end
        for (int i = 0; i < v; i++) begin
            for (int k = 0; k < 3; k++) begin
                coord[i][k] = $urandom;
            end
        end
    endtask

    // index records, zero word, vertex records with a nonzero flag, zero word
    task automatic load_scene();
        for (int t = 0; t < n_tri; t++) begin
            for (int k = 0; k < 3; k++) begin
                send_word(tri_idx[t][k]);
            end
            send_word(tri_sid[t]);
        end
        repeat (4) send_word('0);
        for (int i = 0; i < n_vtx; i++) begin
            for (int k = 0; k < 3; k++) begin
                send_word(coord[i][k]);
            end
            send_word($urandom_range(32'hffff_ffff, 1));
        end
        repeat (4) send_word('0);
        @(negedge clk);
        host_wr = 1'b0;
        while (host_busy) begin
            @(negedge clk);
        end
    endtask

    task automatic request(input int id);
        int prev;
        prev = resp_cnt;
        @(negedge clk);
        exp_id      = id;
        wait_cnt    = 0;
        pending     = 1'b1;
        rd_req      = 1'b1;
        triangle_id = id[tri_id_w-1:0];
        @(negedge clk);
        rd_req = 1'b0;
        wait (resp_cnt != prev);
    endtask

    task automatic walk_ids(input int gap);
        for (int id = 0; id < n_tri; id++) begin
            request(id);
            repeat (gap) @(negedge clk);
        end
    endtask

    initial begin
        int n1;
        int v1;
        int n2;
        int v2;
        int a;
        int b;
        void'($urandom(32'hddaf980e));
        clk         = 1'b0;
        rst_n       = 1'b0;
        host_wr     = 1'b0;
        host_data   = '0;
        rd_req      = 1'b0;
        triangle_id = '0;
        pending     = 1'b0;
        n1 = $urandom_range(80, 48);
        v1 = $urandom_range(96, 40);
        n2 = $urandom_range(40, 16);
        v2 = $urandom_range(48, 20);
        wd_cycles = (4 * (n1 + v1 + n2 + v2 + 4) + 2 * n1 + n2 + 136) * 40;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_reset_low("rd_rdy", rd_rdy);
        check_reset_low("rd_not_valid", rd_not_valid);
        check_reset_low("host_busy", host_busy);

        build_scene(n1, v1);
        load_scene();
        repeat (60) begin
            request($urandom_range(n1 - 1, 0));
            repeat ($urandom_range(3, 0)) @(negedge clk);
        end
        // back to back and then with room for the prefetch to finish
        walk_ids(0);
        walk_ids(6);

        // a stray rd_rdy would show up during the idle gap
        request(n1);
        repeat (6) @(negedge clk);
        request(num_triangle - 1);
        repeat (6) @(negedge clk);
        repeat (5) begin
            request($urandom_range(num_triangle - 1, n1));
            repeat (6) @(negedge clk);
        end
        request($urandom_range(n1 - 1, 0));

        // second request lands on the prefetch of a + 1
        repeat (10) begin
            a = $urandom_range(n1 - 2, 0);
            b = $urandom_range(n1 - 1, 0);
            if (b == a + 1)
                b = (a + 2) % n1;
            request(a);
            request(b);
        end

        build_scene(n2, v2);
        load_scene();
        repeat (30) request($urandom_range(n2 - 1, 0));
        walk_ids(0);
        for (int id = n2; id < n1 && id < n2 + 8; id++) begin
            request(id);
            repeat (6) @(negedge clk);
        end
        request(0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("run stopped by watchdog after %0d cycles, errors %0d", wd_cycles, errors);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* project.f */
verilog/tri_mem_pkg.sv
verilog/single_port_ram.sv
verilog/mem_triangle.sv
verilog/scene_loader.sv
verilog/triangle_store_top.sv
bench/tb_triangle_store.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= tb_triangle_store
RTL_TOP     ?= triangle_store_top
FILELIST    ?= project.f
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing --assert -j 0 -Wno-fatal
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_TEXT   ?= Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation prints the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
